//--- Bender.yml
package:
  name: msx_config_loader

sources:
  - source/msx_layout_pkg.sv
  - source/upload_pkg.sv
  - source/record_decoder.sv
  - source/upload_sequencer.sv
  - source/ram_fill_engine.sv
  - source/slot_layout_table.sv
  - source/msx_config_loader.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_msx_config_loader.sv

//--- dv/config_loader_checks.svh
`ifndef CONFIG_LOADER_CHECKS_SVH
`define CONFIG_LOADER_CHECKS_SVH

// Fill pattern byte for a region offset
function automatic logic [7:0] pattern_ref(logic [2:0] code, logic [8:0] off);
   case (code)
      3'd1: return 8'hFF;
      3'd2: return 8'h00;
      3'd3: return off[8] ? (off[1] ? 8'hFF : 8'h00) : (off[1] ? 8'h00 : 8'hFF);
      3'd4: return off[8] ? (off[0] ? 8'h00 : 8'hFF) : (off[0] ? 8'hFF : 8'h00);
      3'd5: return off[7] ? 8'hFF : 8'h00;
      default: return 8'hFF;
   endcase
endfunction

// Untouched RAM contents
function automatic logic [7:0] bg_byte(int a);
   return 8'(a ^ (a >> 5) ^ (a >> 11));
endfunction

// Walks the source image and builds the expected layout, refs and RAM
function automatic void replay_config(int len);
   int                            addr;
   int                            free;
   int                            nref;
   int                            blocks;
   int                            nbytes;
   int                            s;
   int                            m;
   int                            p;
   logic [7:0]                    h [16];
   logic [7:0]                    did;
   logic [3:0]                    cur;
   msx_layout_pkg::layout_entry_t old [64];
   msx_layout_pkg::layout_entry_t e;
   for (int i = 0; i < 64; i++) begin
      exp_layout[i] = '{mapper: msx_layout_pkg::MAPPER_UNUSED,
                        device: msx_layout_pkg::DEVICE_NONE, ref_ram: 4'd0, offset_ram: 2'd0};
   end
   addr = 0;
   free = 0;
   nref = 0;
   while (addr + 16 <= len) begin
      for (int k = 0; k < 16; k++) h[k] = src_mem[addr + k];
      if ({h[0], h[1], h[2]} != "MSX") break;
      addr += 16;
      if (h[3][7:4] != 4'd2) continue;   // Other record kinds
      did    = h[4];
      blocks = {h[5][2:0], h[6]};
      nbytes = blocks << 6;
      cur    = 4'(nref);
      if (blocks != 0 && (did == 8'd1 || did == 8'd2)) begin
         for (int k = 0; k < nbytes; k++) begin
            exp_ram[free + k] = (did == 8'd1) ? src_mem[addr + k]
                                              : pattern_ref(h[11][2:0], 9'(k));
         end
         if (did == 8'd1) addr += nbytes;
         exp_ref[nref] = '{addr: 27'(free), size: 16'(blocks), ro: (did != 8'd2)};
         nref++;
         free += nbytes;
      end
      old = exp_layout;
      s   = h[3][3:0];
      for (int b = 0; b < 4; b++) begin
         m = h[9][2*b +: 2];
         p = h[10][2*b +: 2];
         e = old[s*4 + b];
         if (m == 1) begin
            e        = old[s*4 + p];
            e.device = msx_layout_pkg::DEVICE_NONE;
         end else if (m >= 2) begin
            e.mapper     = (m == 2) ? msx_layout_pkg::mapper_t'(h[8][3:0])
                                    : msx_layout_pkg::MAPPER_UNUSED;
            e.device     = msx_layout_pkg::device_t'(h[4][3:0]);
            e.ref_ram    = (did == 8'd0) ? 4'd0 : cur;
            e.offset_ram = 2'(p);
         end
         exp_layout[s*4 + b] = e;
      end
   end
   exp_ram_used = free;
   exp_ref_cnt  = nref;
endfunction

task automatic compare_layout(string name, msx_layout_pkg::layout_entry_t exp,
                              msx_layout_pkg::layout_entry_t act);
   if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "stopping on first error");
   end
endtask

task automatic compare_ref(string name, msx_layout_pkg::ram_ref_t exp,
                           msx_layout_pkg::ram_ref_t act);
   if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "stopping on first error");
   end
endtask

task automatic compare_byte(string name, logic [7:0] exp, logic [7:0] act);
   if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "stopping on first error");
   end
endtask

task automatic compare_bit(string name, logic exp, logic act);
   if (exp !== act) begin
      error_count++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "stopping on first error");
   end
endtask

`endif

//--- dv/tb_msx_config_loader.sv
`timescale 1ns/1ps

module tb_msx_config_loader;

   logic                          clk;
   logic                          rst_n;
   logic                          load;
   logic [27:0]                   config_len;
   logic                          busy;
   logic                          done;
   logic                          src_rd;
   logic [27:0]                   src_addr;
   logic                          src_ready;
   logic [7:0]                    src_data;
   logic                          ram_we;
   logic [26:0]                   ram_addr;
   logic [7:0]                    ram_din;
   logic                          ram_ready;
   logic [5:0]                    layout_idx;
   msx_layout_pkg::layout_entry_t layout_entry;
   logic [3:0]                    ref_idx;
   msx_layout_pkg::ram_ref_t      ref_entry;

   logic [7:0]                    src_mem [8192];
   logic [7:0]                    ram_mem [8192];
   logic [7:0]                    exp_ram [8192];
   msx_layout_pkg::layout_entry_t exp_layout [64];
   msx_layout_pkg::ram_ref_t      exp_ref [16];
   logic [7:0]                    src_byte;   // Last accepted source byte
   int                            exp_ram_used;
   int                            exp_ref_cnt;
   int                            img_len;
   int                            error_count;
   int                            cycles;
   int                            budget;
   integer                        seed;
   logic                          bp;
   logic                          check_req;
   string                         test_name;

   `include "config_loader_checks.svh"

   msx_config_loader #(
      .BLOCK_SHIFT (6)
   ) u_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .load         (load),
      .config_len   (config_len),
      .busy         (busy),
      .done         (done),
      .src_rd       (src_rd),
      .src_addr     (src_addr),
      .src_ready    (src_ready),
      .src_data     (src_data),
      .ram_we       (ram_we),
      .ram_addr     (ram_addr),
      .ram_din      (ram_din),
      .ram_ready    (ram_ready),
      .layout_idx   (layout_idx),
      .layout_entry (layout_entry),
      .ref_idx      (ref_idx),
      .ref_entry    (ref_entry)
   );

   always #20 clk = ~clk;

   // Source and RAM models
   always @(posedge clk) begin : mem_models
      logic        acc;
      logic [12:0] rd_a;
      acc  = src_rd && src_ready;
      rd_a = src_addr[12:0];
      if (ram_we && ram_ready) ram_mem[ram_addr[12:0]] = ram_din;
      #1;
      if (acc) src_byte = src_mem[rd_a];
      src_ready = bp ? (($random(seed) & 3) != 0) : 1'b1;
      ram_ready = bp ? (($random(seed) & 3) != 0) : 1'b1;
      src_data  = src_ready ? src_byte : 8'hxx;   // Valid only with src_ready
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > budget) begin
         $display("timeout: done never arrived within %0d cycles", budget);
         $display("Simulation failed");
         $fatal(1, "watchdog expired");
      end
   end

   task automatic check_results();
      for (int i = 0; i < 64; i++) begin
         layout_idx = 6'(i);
         #1;
         compare_layout($sformatf("%s layout %0d", test_name, i), exp_layout[i], layout_entry);
      end
      for (int i = 0; i < exp_ref_cnt; i++) begin
         ref_idx = 4'(i);
         #1;
         compare_ref($sformatf("%s ref %0d", test_name, i), exp_ref[i], ref_entry);
      end
      for (int a = 0; a < exp_ram_used; a++) begin
         compare_byte($sformatf("%s ram %0d", test_name, a), exp_ram[a], ram_mem[a]);
      end
      for (int a = exp_ram_used; a < exp_ram_used + 64; a++) begin   // Past the last region
         compare_byte($sformatf("%s ram %0d", test_name, a), bg_byte(a), ram_mem[a]);
      end
   endtask

   always begin
      wait (check_req);
      check_results();
      check_req = 1'b0;
   end

   task automatic add_record(logic good, logic [3:0] kind, logic [3:0] slot,
                             logic [7:0] did, int blocks, logic [3:0] mapper,
                             logic [7:0] mode, logic [7:0] param, logic [2:0] pat);
      logic [7:0] h [16];
      h = '{8'h4D, 8'h53, good ? 8'h58 : 8'h59, {kind, slot}, did,
            {5'd0, 3'(blocks >> 8)}, 8'(blocks), 8'h00, {4'h0, mapper},
            mode, param, {5'd0, pat}, 8'h00, 8'h00, 8'h00, 8'h00};
      for (int k = 0; k < 16; k++) src_mem[img_len + k] = h[k];
      img_len += 16;
      if (good && kind == 4'd2 && did == 8'd1) begin   // ROM payload
         for (int k = 0; k < (blocks << 6); k++) begin
            src_mem[img_len] = 8'($random(seed));
            img_len++;
         end
      end
   endtask

   task automatic run_test(string name, int len);
      test_name = name;
      for (int a = 0; a < 8192; a++) ram_mem[a] = bg_byte(a);
      replay_config(len);
      budget += (len + exp_ram_used) * 8 + 64;
      @(posedge clk);
      #1;
      load       = 1'b1;
      config_len = 28'(len);
      @(posedge clk);
      #1;
      load = 1'b0;
      do begin
         compare_bit({name, " busy"}, 1'b1, busy);
         @(posedge clk);
         #1;
      end while (!done);
      compare_bit({name, " busy after done"}, 1'b0, busy);
      check_req = 1'b1;
      wait (!check_req);
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      load        = 1'b0;
      config_len  = '0;
      src_ready   = 1'b1;
      src_data    = 8'h00;
      src_byte    = 8'h00;
      ram_ready   = 1'b1;
      layout_idx  = '0;
      ref_idx     = '0;
      seed        = 32'h9a9c;
      bp          = 1'b0;
      check_req   = 1'b0;
      error_count = 0;
      cycles      = 0;
      budget      = 16;
      img_len     = 0;
      add_record(1, 4'd2, 4'd0, 8'd1, 2, 4'd4, 8'h0A, 8'h04, 3'd0);
      for (int k = 1; k < 8; k++) begin
         add_record(1, 4'd2, 4'(k + 1), 8'd2, 9, 4'd2, 8'(k * 37), 8'(k * 91), 3'(k));
      end
      add_record(1, 4'd2, 4'd0, 8'd0, 3, 4'd5, 8'hC0, 8'h80, 3'd0);   // ROM_NONE
      add_record(1, 4'd2, 4'd0, 8'd0, 0, 4'd1, 8'h10, 8'h00, 3'd0);   // Mirror of page 0
      add_record(1, 4'd4, 4'd0, 8'd1, 1, 4'd3, 8'hFF, 8'h55, 3'd0);
      add_record(0, 4'd2, 4'd0, 8'd2, 1, 4'd3, 8'hAA, 8'h00, 3'd1);
      add_record(1, 4'd2, 4'd1, 8'd2, 1, 4'd3, 8'hAA, 8'h00, 3'd1);
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      if (busy !== 1'b0) begin
         $display("busy is not low after reset");
         $display("Simulation failed");
         $fatal(1, "stopping on first error");
      end
      for (int pass = 0; pass < 2; pass++) begin
         bp = pass[0];
         run_test(bp ? "empty_bp" : "empty", 0);
         run_test(bp ? "full_bp" : "full", img_len);
      end
      if (error_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+dv
source/msx_layout_pkg.sv
source/upload_pkg.sv
source/record_decoder.sv
source/upload_sequencer.sv
source/ram_fill_engine.sv
source/slot_layout_table.sv
source/msx_config_loader.sv
dv/tb_msx_config_loader.sv

//--- source/msx_config_loader.sv
`timescale 1ns/1ps

module msx_config_loader #(
   parameter int SRC_ADDR_W  = 28,
   parameter int RAM_ADDR_W  = 27,
   parameter int BLOCK_SHIFT = 14,
   parameter int REF_W       = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          load,
   input  logic [SRC_ADDR_W-1:0]         config_len,
   output logic                          busy,
   output logic                          done,
   output logic                          src_rd,
   output logic [SRC_ADDR_W-1:0]         src_addr,
   input  logic                          src_ready,
   input  logic [7:0]                    src_data,
   output logic                          ram_we,
   output logic [RAM_ADDR_W-1:0]         ram_addr,
   output logic [7:0]                    ram_din,
   input  logic                          ram_ready,
   input  logic [5:0]                    layout_idx,
   output msx_layout_pkg::layout_entry_t layout_entry,
   input  logic [REF_W-1:0]              ref_idx,
   output msx_layout_pkg::ram_ref_t      ref_entry
);
   logic                  clear_start;
   logic                  clear_done;
   logic                  byte_valid;
   logic [3:0]            byte_idx;
   logic                  byte_req;
   logic                  fill_start;
   logic                  fill_done;
   logic                  commit;
   logic [REF_W-1:0]      ref_cur;
   upload_pkg::record_t   record;
   upload_pkg::fill_job_t fill_job;

   upload_sequencer #(
      .SRC_ADDR_W (SRC_ADDR_W)
   ) u_sequencer (
      .clk         (clk),
      .rst_n       (rst_n),
      .load        (load),
      .config_len  (config_len),
      .busy        (busy),
      .done        (done),
      .src_rd      (src_rd),
      .src_addr    (src_addr),
      .src_ready   (src_ready),
      .src_data    (src_data),
      .byte_valid  (byte_valid),
      .byte_idx    (byte_idx),
      .clear_start (clear_start),
      .clear_done  (clear_done),
      .record      (record),
      .fill_start  (fill_start),
      .fill_job    (fill_job),
      .byte_req    (byte_req),
      .fill_done   (fill_done),
      .commit      (commit)
   );

   record_decoder u_decoder (
      .clk        (clk),
      .rst_n      (rst_n),
      .byte_valid (byte_valid),
      .byte_idx   (byte_idx),
      .src_data   (src_data),
      .record     (record)
   );

   ram_fill_engine #(
      .RAM_ADDR_W  (RAM_ADDR_W),
      .BLOCK_SHIFT (BLOCK_SHIFT),
      .REF_W       (REF_W)
   ) u_fill (
      .clk        (clk),
      .rst_n      (rst_n),
      .load       (load),
      .fill_start (fill_start),
      .fill_job   (fill_job),
      .src_data   (src_data),
      .byte_valid (byte_valid),
      .byte_req   (byte_req),
      .ram_we     (ram_we),
      .ram_addr   (ram_addr),
      .ram_din    (ram_din),
      .ram_ready  (ram_ready),
      .fill_done  (fill_done),
      .ref_cur    (ref_cur),
      .ref_idx    (ref_idx),
      .ref_entry  (ref_entry)
   );

   slot_layout_table #(
      .REF_W (REF_W)
   ) u_layout (
      .clk          (clk),
      .rst_n        (rst_n),
      .clear_start  (clear_start),
      .clear_done   (clear_done),
      .commit       (commit),
      .record       (record),
      .ref_cur      (ref_cur),
      .layout_idx   (layout_idx),
      .layout_entry (layout_entry)
   );

endmodule

//--- source/msx_layout_pkg.sv
package msx_layout_pkg;

   // Mapper codes from the low nibble of the 8-bit config code
   typedef enum logic [3:0] {
      MAPPER_UNUSED     = 4'd0,
      MAPPER_NONE       = 4'd1,
      MAPPER_RAM        = 4'd2,
      MAPPER_ASCII8     = 4'd3,
      MAPPER_ASCII16    = 4'd4,
      MAPPER_KONAMI     = 4'd5,
      MAPPER_KONAMI_SCC = 4'd6,
      MAPPER_FMPAC      = 4'd7,
      MAPPER_GM2        = 4'd8
   } mapper_t;

   typedef enum logic [3:0] {
      DEVICE_NONE   = 4'd0,
      DEVICE_ROM    = 4'd1,
      DEVICE_FDC    = 4'd2,
      DEVICE_MFRSD0 = 4'd3,
      DEVICE_OPL3   = 4'd4
   } device_t;

   typedef enum logic [7:0] {
      ROM_NONE  = 8'd0,
      ROM_ROM   = 8'd1,
      ROM_RAM   = 8'd2,
      ROM_FDC   = 8'd3,
      ROM_FMPAC = 8'd4
   } data_id_t;

   // One 16 KB page of one slot/subslot
   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;   // Page offset inside the RAM region
   } layout_entry_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [15:0] size;        // In blocks
      logic        ro;
   } ram_ref_t;

endpackage

//--- source/ram_fill_engine.sv
`timescale 1ns/1ps

module ram_fill_engine #(
   parameter int RAM_ADDR_W  = 27,
   parameter int BLOCK_SHIFT = 14,
   parameter int REF_W       = 4
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     load,
   input  logic                     fill_start,
   input  upload_pkg::fill_job_t    fill_job,
   input  logic [7:0]               src_data,
   input  logic                     byte_valid,
   output logic                     byte_req,
   output logic                     ram_we,
   output logic [RAM_ADDR_W-1:0]    ram_addr,
   output logic [7:0]               ram_din,
   input  logic                     ram_ready,
   output logic                     fill_done,
   output logic [REF_W-1:0]         ref_cur,
   input  logic [REF_W-1:0]         ref_idx,
   output msx_layout_pkg::ram_ref_t ref_entry
);
   localparam int CNT_W = 11 + BLOCK_SHIFT;

   logic [RAM_ADDR_W-1:0]     next_free;
   logic [RAM_ADDR_W-1:0]     base;
   logic [CNT_W-1:0]          job_len;
   logic [CNT_W-1:0]          total;
   logic [CNT_W-1:0]          off;
   logic [CNT_W-1:0]          req_left;
   logic [REF_W-1:0]          ref_cnt;
   logic                      active;
   logic                      copy;
   upload_pkg::fill_pattern_t pattern;
   logic [1:0]                outst;    // Requested, not yet delivered
   logic [1:0]                held;
   logic [7:0]                buf_q [2];
   logic                      wr_ptr;
   logic                      rd_ptr;
   logic                      take;
   msx_layout_pkg::ram_ref_t  ref_tab [2**REF_W];

   function automatic logic [7:0] pattern_byte(upload_pkg::fill_pattern_t pat,
                                               logic [8:0] pos);
      case (pat)
         upload_pkg::ZEROS:   return 8'h00;
         upload_pkg::CHECK_A: return (pos[8] ~^ pos[1]) ? 8'hFF : 8'h00;
         upload_pkg::CHECK_B: return (pos[8] ^ pos[0]) ? 8'hFF : 8'h00;
         upload_pkg::HALVES:  return pos[7] ? 8'hFF : 8'h00;
         default:             return 8'hFF;
      endcase
   endfunction

   assign job_len   = CNT_W'(fill_job.blocks) << BLOCK_SHIFT;
   assign take      = byte_valid && active && copy;
   assign byte_req  = active && copy && (req_left != '0) && ((outst + held) < 2'd2);
   assign ram_we    = active && (!copy || (held != 2'd0)) && ram_ready;
   assign ram_addr  = base + RAM_ADDR_W'(off);
   assign ram_din   = copy ? buf_q[rd_ptr] : pattern_byte(pattern, off[8:0]);
   assign ref_entry = ref_tab[ref_idx];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active    <= 1'b0;
         fill_done <= 1'b0;
         outst     <= '0;
         held      <= '0;
         wr_ptr    <= 1'b0;
         rd_ptr    <= 1'b0;
         off       <= '0;
         req_left  <= '0;
         next_free <= '0;
         ref_cnt   <= '0;
         ref_cur   <= '0;
      end else begin
         fill_done <= 1'b0;
         outst     <= outst + 2'(byte_req) - 2'(take);
         held      <= held + 2'(take) - 2'(ram_we && copy);
         if (take) wr_ptr <= !wr_ptr;
         if (ram_we && copy) rd_ptr <= !rd_ptr;
         if (byte_req) req_left <= req_left - 1'b1;
         if (load) begin
            next_free <= '0;
            ref_cnt   <= '0;
         end
         if (fill_start) begin
            ref_cur  <= ref_cnt;
            off      <= '0;
            req_left <= (fill_job.pattern == upload_pkg::COPY) ? job_len : '0;
            if (fill_job.blocks == 11'd0) begin
               fill_done <= 1'b1;
            end else begin
               active    <= 1'b1;
               next_free <= next_free + RAM_ADDR_W'(job_len);   // Back to back
            end
         end
         if (ram_we) begin
            off <= off + 1'b1;
            if (off + 1'b1 == total) begin
               active    <= 1'b0;
               fill_done <= 1'b1;
               ref_cnt   <= ref_cnt + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) buf_q[wr_ptr] <= src_data;
      if (fill_start) begin
         base    <= next_free;
         total   <= job_len;
         pattern <= fill_job.pattern;
         copy    <= (fill_job.pattern == upload_pkg::COPY);
         if (fill_job.blocks != 11'd0) begin
            ref_tab[ref_cnt] <= '{addr: 27'(next_free),
                                  size: 16'(fill_job.blocks),
                                  ro:   fill_job.ro};
         end
      end
   end

endmodule

//--- source/record_decoder.sv
`timescale 1ns/1ps

module record_decoder (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                byte_valid,
   input  logic [3:0]          byte_idx,
   input  logic [7:0]          src_data,
   output upload_pkg::record_t record
);
   localparam int USED_BYTES = 12;   // Bytes 12..15 carry nothing we keep

   logic [7:0]          conf [USED_BYTES];
   upload_pkg::record_t next_rec;
   logic                last_byte;

   assign last_byte = byte_valid && (byte_idx == 4'(upload_pkg::REC_BYTES - 1));

   always_ff @(posedge clk) begin
      if (byte_valid && (byte_idx < 4'(USED_BYTES))) begin
         conf[byte_idx] <= src_data;
      end
   end

   always_comb begin
      next_rec                  = '0;
      next_rec.magic_ok         = ({conf[0], conf[1], conf[2]} == upload_pkg::MAGIC);
      next_rec.kind             = upload_pkg::rec_kind_t'(conf[3][7:4]);
      next_rec.slot_sub         = conf[3][3:0];          // {slot, subslot}
      next_rec.mem_kind.data_id = msx_layout_pkg::data_id_t'(conf[4]);
      next_rec.blocks           = {conf[5][2:0], conf[6]};
      next_rec.mapper           = msx_layout_pkg::mapper_t'(conf[8][3:0]);
      next_rec.mode             = conf[9];
      next_rec.param            = conf[10];
      next_rec.pattern          = upload_pkg::fill_pattern_t'(conf[11][2:0]);
   end

   // Latched on the last byte so copy traffic cannot disturb it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         record <= '0;
      end else if (last_byte) begin
         record <= next_rec;
      end
   end

endmodule

//--- source/slot_layout_table.sv
`timescale 1ns/1ps

module slot_layout_table #(
   parameter int REF_W = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          clear_start,
   output logic                          clear_done,
   input  logic                          commit,
   input  upload_pkg::record_t           record,
   input  logic [REF_W-1:0]              ref_cur,
   input  logic [5:0]                    layout_idx,
   output msx_layout_pkg::layout_entry_t layout_entry
);
   logic [5:0]                    clr_idx;
   logic                          clr_active;
   msx_layout_pkg::layout_entry_t tab [64];   // {slot, subslot, page}

   function automatic msx_layout_pkg::layout_entry_t page_entry(
      logic [1:0]                    m,
      logic [1:0]                    p,
      msx_layout_pkg::layout_entry_t cur,
      msx_layout_pkg::layout_entry_t mirror,
      upload_pkg::record_t           rec,
      logic [3:0]                    ref_ram);
      msx_layout_pkg::layout_entry_t e;
      e = cur;
      case (m)
         2'd1: begin   // Mirror another page of the same slot
            e        = mirror;
            e.device = msx_layout_pkg::DEVICE_NONE;
         end
         2'd2, 2'd3: begin
            e.mapper     = (m == 2'd2) ? rec.mapper : msx_layout_pkg::MAPPER_UNUSED;
            e.device     = rec.mem_kind.dev.device;
            e.ref_ram    = (rec.mem_kind.data_id == msx_layout_pkg::ROM_NONE) ? 4'd0 : ref_ram;
            e.offset_ram = p;
         end
         default: ;
      endcase
      return e;
   endfunction

   assign clear_done   = clr_active && (clr_idx == 6'd63);
   assign layout_entry = tab[layout_idx];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clr_active <= 1'b0;
         clr_idx    <= '0;
      end else if (clear_start) begin
         clr_active <= 1'b1;
         clr_idx    <= '0;
      end else if (clr_active) begin
         clr_idx <= clr_idx + 1'b1;
         if (clr_idx == 6'd63) clr_active <= 1'b0;
      end
   end

   // Mirror sources read the contents before this commit
   always_ff @(posedge clk) begin
      if (clr_active) begin
         tab[clr_idx] <= '{mapper:     msx_layout_pkg::MAPPER_UNUSED,
                           device:     msx_layout_pkg::DEVICE_NONE,
                           ref_ram:    4'd0,
                           offset_ram: 2'd0};
      end else if (commit) begin
         for (int b = 0; b < 4; b++) begin
            tab[{record.slot_sub, 2'(b)}] <= page_entry(
               record.mode[2*b +: 2],
               record.param[2*b +: 2],
               tab[{record.slot_sub, 2'(b)}],
               tab[{record.slot_sub, record.param[2*b +: 2]}],
               record,
               4'(ref_cur));
         end
      end
   end

endmodule

//--- source/upload_pkg.sv
package upload_pkg;

   localparam int          REC_BYTES = 16;
   localparam logic [23:0] MAGIC     = {"M", "S", "X"};

   // Upper nibble of record byte 3
   typedef enum logic [3:0] {
      KIND_SLOT_A        = 4'd0,
      KIND_SLOT_B        = 4'd1,
      KIND_SLOT_INTERNAL = 4'd2,
      KIND_KBD_LAYOUT    = 4'd3,
      KIND_CONFIG        = 4'd4,
      KIND_DEVICE        = 4'd5
   } rec_kind_t;

   // Byte 4 names the memory device and the payload kind at once
   typedef union packed {
      struct packed {
         logic [3:0]              rsv;
         msx_layout_pkg::device_t device;
      } dev;
      msx_layout_pkg::data_id_t data_id;
   } mem_kind_u;

   typedef enum logic [2:0] {
      COPY    = 3'd0,
      ONES    = 3'd1,
      ZEROS   = 3'd2,
      CHECK_A = 3'd3,
      CHECK_B = 3'd4,
      HALVES  = 3'd5
   } fill_pattern_t;   // 6 and 7 fill with FF

   typedef struct packed {
      logic                    magic_ok;
      rec_kind_t               kind;
      logic [3:0]              slot_sub;
      mem_kind_u               mem_kind;
      logic [10:0]             blocks;
      msx_layout_pkg::mapper_t mapper;
      logic [7:0]              mode;     // 2 bits per page
      logic [7:0]              param;    // 2 bits per page
      fill_pattern_t           pattern;
   } record_t;

   typedef struct packed {
      logic [10:0]   blocks;   // Zero means no region
      fill_pattern_t pattern;
      logic          ro;
   } fill_job_t;

endpackage

//--- source/upload_sequencer.sv
`timescale 1ns/1ps

module upload_sequencer #(
   parameter int SRC_ADDR_W = 28
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  load,
   input  logic [SRC_ADDR_W-1:0] config_len,
   output logic                  busy,
   output logic                  done,
   output logic                  src_rd,
   output logic [SRC_ADDR_W-1:0] src_addr,
   input  logic                  src_ready,
   input  logic [7:0]            src_data,
   output logic                  byte_valid,
   output logic [3:0]            byte_idx,
   output logic                  clear_start,
   input  logic                  clear_done,
   input  upload_pkg::record_t   record,
   output logic                  fill_start,
   output upload_pkg::fill_job_t fill_job,
   input  logic                  byte_req,
   input  logic                  fill_done,
   output logic                  commit
);
   typedef enum logic [2:0] {
      S_IDLE,
      S_CLEAR,
      S_NEXT,
      S_HDR,
      S_CHECK,
      S_FILL
   } state_t;

   state_t              state;
   logic [4:0]          iss_cnt;    // Header reads accepted
   logic [3:0]          rcv_cnt;
   logic                pend;       // Read accepted, data not yet returned
   logic [1:0]          copy_req;   // Copy bytes asked for, not yet accepted
   logic                accept;
   logic                rom_rom;
   logic                rom_ram;
   logic [SRC_ADDR_W:0] hdr_end;

   assign accept     = src_rd && src_ready;
   assign byte_valid = pend && src_ready;
   assign byte_idx   = (state == S_HDR) ? rcv_cnt : 4'd0;
   assign src_rd     = ((state == S_HDR) && !iss_cnt[4]) ||
                       ((state == S_FILL) && (copy_req != 2'd0));
   assign hdr_end    = {1'b0, src_addr} + (SRC_ADDR_W + 1)'(upload_pkg::REC_BYTES);
   assign rom_rom    = (record.mem_kind.data_id == msx_layout_pkg::ROM_ROM);
   assign rom_ram    = (record.mem_kind.data_id == msx_layout_pkg::ROM_RAM);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= S_IDLE;
         busy        <= 1'b0;
         done        <= 1'b0;
         src_addr    <= '0;
         iss_cnt     <= '0;
         rcv_cnt     <= '0;
         pend        <= 1'b0;
         copy_req    <= '0;
         clear_start <= 1'b0;
         fill_start  <= 1'b0;
         commit      <= 1'b0;
      end else begin
         done        <= 1'b0;
         clear_start <= 1'b0;
         fill_start  <= 1'b0;
         commit      <= 1'b0;
         if (src_ready) begin
            pend <= accept;
         end
         if (accept) begin
            src_addr <= src_addr + 1'b1;
         end
         if (state == S_FILL) begin
            copy_req <= copy_req + 2'(byte_req) - 2'(accept);
         end
         case (state)
            S_IDLE: begin
               if (load) begin
                  busy        <= 1'b1;
                  src_addr    <= '0;
                  clear_start <= 1'b1;
                  state       <= S_CLEAR;
               end
            end
            S_CLEAR: begin
               if (clear_done) state <= S_NEXT;
            end
            S_NEXT: begin
               iss_cnt <= '0;
               rcv_cnt <= '0;
               if (hdr_end > {1'b0, config_len}) begin   // No full header left
                  done  <= 1'b1;
                  busy  <= 1'b0;
                  state <= S_IDLE;
               end else begin
                  state <= S_HDR;
               end
            end
            S_HDR: begin
               if (accept) iss_cnt <= iss_cnt + 1'b1;
               if (byte_valid) begin
                  rcv_cnt <= rcv_cnt + 1'b1;
                  if (rcv_cnt == 4'd15) state <= S_CHECK;
               end
            end
            S_CHECK: begin
               if (!record.magic_ok) begin
                  done  <= 1'b1;
                  busy  <= 1'b0;
                  state <= S_IDLE;
               end else if (record.kind != upload_pkg::KIND_SLOT_INTERNAL) begin
                  state <= S_NEXT;   // Known kind, not handled here
               end else begin
                  fill_start <= 1'b1;
                  copy_req   <= '0;
                  state      <= S_FILL;
               end
            end
            S_FILL: begin
               if (fill_done) begin
                  commit <= 1'b1;
                  state  <= S_NEXT;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_CHECK) begin
         fill_job.blocks  <= (rom_rom || rom_ram) ? record.blocks : 11'd0;
         fill_job.pattern <= rom_rom ? upload_pkg::COPY : record.pattern;
         fill_job.ro      <= !rom_ram;
      end
   end

endmodule
